// File: compile.f
+incdir+verilog
verilog/conv_pkg.sv
verilog/conv_ctrl.sv
verilog/weight_buffer.sv
verilog/ifmap_buffer.sv
verilog/psum_buffer.sv
verilog/pe_array.sv
verilog/conv_unit.sv
tests/tb_conv_unit.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_conv_unit -o sim_conv_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_conv_unit)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
    exit 0
fi
exit 1

// File: tests/tb_conv_unit.sv
`include "conv_params.svh"

module tb_conv_unit import conv_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PASS_CYCLES = 120;   // one pass, loads with gaps and output stalls
    localparam int NUM_PASSES  = 6;
    localparam int TIMEOUT_NS  = 2 * NUM_PASSES * PASS_CYCLES * 20;
    localparam int WAIT_LIMIT  = 64;    // cycles without a handshake

    logic               clk;
    logic               reset;
    logic [`WORD_W-1:0] data_in;
    logic [`WORD_W-1:0] data_out;
    conv_cfg_t          cfg;
    logic               valid_w, valid_if, valid_ip, ready_op;
    logic               ready_w, ready_if, ready_ip, valid_op;

    logic [`WORD_W-1:0] wts [`ROW_NUM][`COL_WORDS];
    logic [`WORD_W-1:0] ifm [`COL_WORDS];
    logic [`WORD_W-1:0] ips [`ROW_NUM];
    logic [`WORD_W-1:0] exp_ps [`ROW_NUM];
    logic [`WORD_W-1:0] words [$];       // stream being sent
    logic [31:0]        seed = 32'h1418;
    int                 errors = 0;

    conv_unit uut (
        .clk(clk), .reset(reset), .data_in(data_in), .data_out(data_out), .cfg(cfg),
        .valid_w(valid_w), .valid_if(valid_if), .valid_ip(valid_ip), .ready_op(ready_op),
        .ready_w(ready_w), .ready_if(ready_if), .ready_ip(ready_ip), .valid_op(valid_op)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("Simulation FAILED");
        $finish;
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic ready_of(input int s);
        case (s)
            0:       return ready_w;
            1:       return ready_if;
            default: return ready_ip;
        endcase
    endfunction

    task automatic set_valid(input int s, input logic v);
        valid_w  = (s == 0) && v;
        valid_if = (s == 1) && v;
        valid_ip = (s == 2) && v;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                 // drive point after the edge
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    // opsum = ipsum + sum of signed lane products, wrapped to 32 bits
    task automatic compute_expected(input int rows, input int cols);
        int acc;
        for (int r = 0; r < rows; r++) begin
            acc = ips[r];
            for (int k = 0; k < cols; k++) begin
                for (int j = 0; j < `LANES; j++) begin
                    acc += int'($signed(wts[r][k][`LANE_W*j +: `LANE_W]))
                         * int'($signed(ifm[k][`LANE_W*j +: `LANE_W]));
                end
            end
            exp_ps[r] = acc;
        end
    endtask

    task automatic send_words(input int s, input logic gaps);
        int          i;
        int          waited;
        logic        v;
        logic        rdy;
        logic [31:0] r;
        i = 0;
        waited = 0;
        while (i < words.size()) begin
            r = lcg_next();
            rdy = ready_of(s);
            v = !(gaps && r[17:16] == 2'b00);   // drop valid about one cycle in four
            set_valid(s, v);
            data_in = words[i];
            next_cycle();
            if (v && rdy) begin
                i++;
                waited = 0;
            end else begin
                waited++;
            end
            if (rdy && !v && !ready_of(s)) begin
                report_error($sformatf("stream %0d ready dropped during a valid gap", s));
            end
            if (waited > WAIT_LIMIT) begin
                $display("stream %0d saw no ready for %0d cycles", s, WAIT_LIMIT);
                errors++;
                break;
            end
        end
        set_valid(s, 1'b0);
        if (ready_of(s)) begin
            report_error($sformatf("stream %0d ready still high after its last word", s));
        end
    endtask

    task automatic recv_opsums(input int n, input logic stall);
        int          i;
        int          waited;
        logic        held;
        logic [31:0] held_word;
        logic [31:0] r;
        i = 0;
        waited = 0;
        held = 1'b0;
        while (i < n) begin
            if (held && !valid_op) begin
                report_error("valid_op dropped while the opsum was stalled");
            end else if (held && data_out !== held_word) begin
                report_error($sformatf("opsum changed from %h to %h while stalled",
                                       held_word, data_out));
            end
            r = lcg_next();
            ready_op = !(stall && r[19:18] == 2'b00);
            if (valid_op && ready_op) begin
                if (data_out !== exp_ps[i]) begin
                    report_error($sformatf("row %0d opsum %h expected %h",
                                           i, data_out, exp_ps[i]));
                end
                i++;
                held = 1'b0;
                waited = 0;
            end else begin
                held = valid_op;
                held_word = data_out;
                waited++;
            end
            if (waited > WAIT_LIMIT) begin
                $display("no opsum was offered for %0d cycles", WAIT_LIMIT);
                errors++;
                break;
            end
            next_cycle();
        end
        ready_op = 1'b0;
        if (valid_op || data_out !== '0) begin
            report_error("output still active after the last row");
        end
    endtask

    task automatic run_pass(input int rows, input int cols, input logic load_w,
                            input logic gaps, input logic stall);
        int wait_n;
        cfg.row_en = `ROW_EN_W'(rows);
        cfg.col_en = `COL_EN_W'(cols);
        compute_expected(rows, cols);
        if (load_w) begin
            words.delete();
            for (int r = 0; r < rows; r++) begin
                for (int k = 0; k < cols; k++) begin
                    words.push_back(wts[r][k]);   // row-major
                end
            end
            send_words(0, gaps);
        end
        words.delete();
        for (int k = 0; k < cols; k++) words.push_back(ifm[k]);
        send_words(1, gaps);
        words.delete();
        for (int r = 0; r < rows; r++) words.push_back(ips[r]);
        send_words(2, gaps);
        wait_n = 0;
        while (!valid_op && wait_n <= WAIT_LIMIT) begin
            next_cycle();
            wait_n++;
        end
        if (wait_n != cols) begin
            report_error($sformatf("valid_op rose %0d cycles after the last ipsum, expected %0d",
                                   wait_n, cols));
        end
        recv_opsums(rows, stall);
    endtask

    task automatic fill_random(input logic zero_ips);
        for (int r = 0; r < `ROW_NUM; r++) begin
            for (int k = 0; k < `COL_WORDS; k++) wts[r][k] = lcg_next();
            ips[r] = zero_ips ? '0 : lcg_next();
        end
        for (int k = 0; k < `COL_WORDS; k++) ifm[k] = lcg_next();
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic test_reset_idle();
        if (ready_w || ready_if || ready_ip || valid_op || data_out !== '0) begin
            report_error("outputs not idle after reset");
        end
        valid_ip = 1'b1;                    // ipsum alone must not start a pass
        repeat (4) begin
            next_cycle();
            if (ready_w || ready_if || ready_ip || valid_op) begin
                report_error("a ready or valid rose on valid_ip alone");
            end
        end
        valid_ip = 1'b0;
        next_cycle();
    endtask

    task automatic test_full_pass();
        fill_random(1'b1);
        run_pass(`ROW_NUM, `COL_WORDS, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_weight_reuse();
        for (int k = 0; k < `COL_WORDS; k++) ifm[k] = lcg_next();
        for (int r = 0; r < `ROW_NUM; r++) ips[r] = lcg_next();
        run_pass(`ROW_NUM, `COL_WORDS, 1'b0, 1'b0, 1'b0);   // weights kept
    endtask

    task automatic test_partial_cfg();
        fill_random(1'b0);
        for (int r = 0; r < `ROW_NUM; r++) ips[r] = -(lcg_next() & 32'hf_ffff) - 1;
        run_pass(3, 2, 1'b1, 1'b0, 1'b0);
    endtask

    task automatic test_backpressure();
        fill_random(1'b0);
        run_pass(5, 3, 1'b1, 1'b1, 1'b1);
    endtask

    task automatic test_extreme_lanes();
        for (int r = 0; r < `ROW_NUM; r++) begin
            for (int k = 0; k < `COL_WORDS; k++) wts[r][k] = 32'h8080_8080;
            ips[r] = 32'h7fff_fff0 - r;     // wraps past the top
        end
        for (int k = 0; k < `COL_WORDS; k++) ifm[k] = 32'h8080_8080;
        run_pass(`ROW_NUM, `COL_WORDS, 1'b1, 1'b0, 1'b0);
    endtask

    initial begin
        reset = 1'b1;
        data_in = '0;
        cfg = '0;
        valid_w = 1'b0;
        valid_if = 1'b0;
        valid_ip = 1'b0;
        ready_op = 1'b0;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        test_reset_idle();
        test_full_pass();
        test_weight_reuse();
        test_partial_cfg();
        test_backpressure();
        test_extreme_lanes();
        $display("tests run: 6, errors: %0d", errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/conv_unit.sv
`include "conv_params.svh"

module conv_unit import conv_pkg::*; (
    input  logic               clk,
    input  logic               reset,
    input  logic [`WORD_W-1:0] data_in,
    output logic [`WORD_W-1:0] data_out,
    input  conv_cfg_t          cfg,
    input  logic               valid_w,
    input  logic               valid_if,
    input  logic               valid_ip,
    input  logic               ready_op,
    output logic               ready_w,
    output logic               ready_if,
    output logic               ready_ip,
    output logic               valid_op
);

    buf_ctrl_t  bctl;
    row_words_t weights;
    glb_word_t  ifmap;
    psum_vec_t  pe_sum;

    conv_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .cfg      (cfg),
        .valid_w  (valid_w),
        .valid_if (valid_if),
        .valid_ip (valid_ip),
        .ready_op (ready_op),
        .ready_w  (ready_w),
        .ready_if (ready_if),
        .ready_ip (ready_ip),
        .valid_op (valid_op),
        .bctl     (bctl)
    );

    // ------------------------------
    // buffers and array
    // ------------------------------
    weight_buffer u_wbuf (
        .clk     (clk),
        .reset   (reset),
        .cfg     (cfg),
        .bctl    (bctl),
        .data_in (data_in),
        .weights (weights)      // to every row
    );

    ifmap_buffer u_ifbuf (
        .clk     (clk),
        .reset   (reset),
        .bctl    (bctl),
        .data_in (data_in),
        .ifmap   (ifmap)        // broadcast word
    );

    pe_array u_pe (
        .weights (weights),
        .ifmap   (ifmap),
        .pe_sum  (pe_sum)
    );

    psum_buffer u_psbuf (
        .clk      (clk),
        .reset    (reset),
        .bctl     (bctl),
        .data_in  (data_in),
        .pe_sum   (pe_sum),
        .data_out (data_out)    // opsum back to the global buffer
    );

endmodule

// File: verilog/pe_array.sv
`include "conv_params.svh"

module pe_array import conv_pkg::*; (
    input  row_words_t weights,
    input  glb_word_t  ifmap,
    output psum_vec_t  pe_sum
);

    for (genvar r = 0; r < `ROW_NUM; r++) begin : g_row
        logic signed [2*`LANE_W-1:0] prod [`LANES];
        logic signed [2*`LANE_W:0]   pair [`LANES/2];
        logic signed [2*`LANE_W+1:0] total;

        // ------------------------------
        // lane products
        // ------------------------------
        always_comb begin
            for (int j = 0; j < `LANES; j++) begin
                prod[j] = $signed(weights[r].lanes[j]) * $signed(ifmap.lanes[j]);
            end
        end

        // two-level reducer
        always_comb begin
            for (int p = 0; p < `LANES/2; p++) begin
                pair[p] = prod[2*p] + prod[2*p+1];
            end
            total = pair[0] + pair[1];
        end

        assign pe_sum[r] = `WORD_W'(total);  // sign extended
    end

endmodule

// File: verilog/psum_buffer.sv
`include "conv_params.svh"

module psum_buffer import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  buf_ctrl_t bctl,
    input  glb_word_t data_in,
    input  psum_vec_t pe_sum,
    output glb_word_t data_out
);

    localparam int ROW_AW = $clog2(`ROW_NUM);

    logic [`WORD_W-1:0]  ps_mem [`ROW_NUM];
    logic [`ROW_NUM-1:0] loaded;              // rows given an ipsum this pass
    logic [ROW_AW-1:0]   row_sel;

    assign row_sel = bctl.idx[ROW_AW-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            loaded <= '0;
        end else if (bctl.ip_wr) begin
            loaded[row_sel] <= 1'b1;
        end else if (bctl.first_acc) begin
            loaded <= '0;                     // consumed by first accumulate
        end
    end

    // ------------------------------
    // load and accumulate in place
    // ------------------------------
    always_ff @(posedge clk) begin
        if (bctl.ip_wr) begin
            ps_mem[row_sel] <= data_in.psum;
        end else if (bctl.acc_en) begin
            for (int r = 0; r < `ROW_NUM; r++) begin
                if (bctl.first_acc && !loaded[r]) begin
                    ps_mem[r] <= pe_sum[r];   // start unloaded rows from zero
                end else begin
                    ps_mem[r] <= ps_mem[r] + pe_sum[r];
                end
            end
        end
    end

    always_comb begin
        data_out.psum = bctl.rd_out ? ps_mem[row_sel] : '0;
    end

endmodule

// File: verilog/ifmap_buffer.sv
`include "conv_params.svh"

module ifmap_buffer import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  buf_ctrl_t bctl,
    input  glb_word_t data_in,
    output glb_word_t ifmap
);

    localparam int COL_AW = $clog2(`COL_WORDS);

    glb_word_t if_mem [`COL_WORDS];  // one pixel

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int k = 0; k < `COL_WORDS; k++) begin
                if_mem[k] <= '0;
            end
        end else if (bctl.if_wr) begin
            if_mem[bctl.idx[COL_AW-1:0]] <= data_in;
        end
    end

    // broadcast only while computing
    assign ifmap = bctl.acc_en ? if_mem[bctl.idx[COL_AW-1:0]] : '0;

endmodule

// File: verilog/weight_buffer.sv
`include "conv_params.svh"

module weight_buffer import conv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  conv_cfg_t  cfg,
    input  buf_ctrl_t  bctl,
    input  glb_word_t  data_in,
    output row_words_t weights
);

    localparam int ROW_AW = $clog2(`ROW_NUM);
    localparam int COL_AW = $clog2(`COL_WORDS);

    glb_word_t         w_mem [`ROW_NUM][`COL_WORDS];
    logic [ROW_AW-1:0] wr_row;
    logic [COL_AW-1:0] wr_col;
    logic              col_wrap;

    assign col_wrap = (wr_col == COL_AW'(cfg.col_en - 1'b1));

    // row-major fill, col_en words per row
    always_ff @(posedge clk) begin
        if (reset || bctl.w_start) begin
            wr_row <= '0;
            wr_col <= '0;
        end else if (bctl.w_wr) begin
            if (col_wrap) begin
                wr_col <= '0;
                wr_row <= wr_row + 1'b1;
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bctl.w_wr) begin
            w_mem[wr_row][wr_col] <= data_in;
        end
    end

    // same word column to every row
    always_comb begin
        for (int r = 0; r < `ROW_NUM; r++) begin
            weights[r] = w_mem[r][bctl.idx[COL_AW-1:0]];
        end
    end

endmodule

// File: verilog/conv_ctrl.sv
`include "conv_params.svh"

module conv_ctrl import conv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  conv_cfg_t cfg,
    input  logic      valid_w,
    input  logic      valid_if,
    input  logic      valid_ip,
    input  logic      ready_op,
    output logic      ready_w,
    output logic      ready_if,
    output logic      ready_ip,
    output logic      valid_op,
    output buf_ctrl_t bctl
);

    phase_t            phase;
    phase_t            next_phase;
    logic [`CNT_W-1:0] cnt;
    logic [`CNT_W-1:0] w_last;
    logic [`CNT_W-1:0] row_last;
    logic [`CNT_W-1:0] col_last;
    logic              w_hs;
    logic              if_hs;
    logic              ip_hs;
    logic              op_hs;
    logic              advance;

    // ------------------------------
    // end counts from cfg
    // ------------------------------
    assign w_last   = `CNT_W'(cfg.row_en) * `CNT_W'(cfg.col_en) - `CNT_W'(1);
    assign row_last = `CNT_W'(cfg.row_en) - `CNT_W'(1);  // ipsum / opsum
    assign col_last = `CNT_W'(cfg.col_en) - `CNT_W'(1);  // ifmap / compute

    assign ready_w  = (phase == WEIGHT_LOAD);
    assign ready_if = (phase == IFMAP_LOAD);
    assign ready_ip = (phase == IPSUM_LOAD);
    assign valid_op = (phase == OPSUM_OUT);

    assign w_hs  = ready_w && valid_w;
    assign if_hs = ready_if && valid_if;
    assign ip_hs = ready_ip && valid_ip;
    assign op_hs = valid_op && ready_op;

    assign advance = w_hs || if_hs || ip_hs || op_hs || (phase == COMPUTE);

    // ------------------------------
    // phase sequencing
    // ------------------------------
    always_comb begin
        next_phase = phase;
        case (phase)
            IDLE: begin
                if (valid_w) begin
                    next_phase = WEIGHT_LOAD;  // new weights win
                end else if (valid_if) begin
                    next_phase = IFMAP_LOAD;   // reuse stored weights
                end
            end
            WEIGHT_LOAD: if (w_hs && cnt == w_last) next_phase = IFMAP_LOAD;
            IFMAP_LOAD:  if (if_hs && cnt == col_last) next_phase = IPSUM_LOAD;
            IPSUM_LOAD:  if (ip_hs && cnt == row_last) next_phase = COMPUTE;
            COMPUTE:     if (cnt == col_last) next_phase = OPSUM_OUT;
            OPSUM_OUT:   if (op_hs && cnt == row_last) next_phase = IDLE;
            default:     next_phase = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= IDLE;
            cnt   <= '0;
        end else begin
            phase <= next_phase;
            if (next_phase != phase) begin
                cnt <= '0;                   // restart on every phase change
            end else if (advance) begin
                cnt <= cnt + `CNT_W'(1);
            end
        end
    end

    // ------------------------------
    // buffer controls
    // ------------------------------
    assign bctl.w_start   = (phase == IDLE) && (next_phase == WEIGHT_LOAD);
    assign bctl.w_wr      = w_hs;
    assign bctl.if_wr     = if_hs;
    assign bctl.ip_wr     = ip_hs;
    assign bctl.acc_en    = (phase == COMPUTE);
    assign bctl.first_acc = (phase == COMPUTE) && (cnt == '0);
    assign bctl.rd_out    = valid_op;
    assign bctl.idx       = cnt;

endmodule

// File: verilog/conv_pkg.sv
`include "conv_params.svh"

package conv_pkg;

    // one bus word, read as byte lanes or as a single psum
    typedef union packed {
        logic signed [`LANES-1:0][`LANE_W-1:0] lanes;  // lane 0 in low byte
        logic signed [`WORD_W-1:0]             psum;
    } glb_word_t;

    typedef enum logic [2:0] {
        IDLE,
        WEIGHT_LOAD,
        IFMAP_LOAD,
        IPSUM_LOAD,
        COMPUTE,
        OPSUM_OUT
    } phase_t;

    typedef struct packed {
        logic [`ROW_EN_W-1:0] row_en;  // active rows, 1..8
        logic [`COL_EN_W-1:0] col_en;  // words per row, 1..4
    } conv_cfg_t;

    typedef struct packed {
        logic             w_start;    // entering weight load
        logic             w_wr;
        logic             if_wr;
        logic             ip_wr;
        logic             acc_en;     // whole compute phase
        logic             first_acc;  // first compute cycle
        logic             rd_out;
        logic [`CNT_W-1:0] idx;
    } buf_ctrl_t;

    typedef glb_word_t [`ROW_NUM-1:0] row_words_t;
    typedef logic signed [`ROW_NUM-1:0][`WORD_W-1:0] psum_vec_t;

endpackage

// File: verilog/conv_params.svh
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// ------------------------------
// array size
// ------------------------------
`define ROW_NUM   8     // output channels per pass
`define COL_WORDS 4     // bus words per weight row / ifmap pixel

// ------------------------------
// bus and lane widths
// ------------------------------
`define LANES     4     // signed lanes per bus word
`define LANE_W    8
`define WORD_W    32    // bus word and psum width
`define ROW_EN_W  4     // row_en holds 1..8
`define COL_EN_W  3     // col_en holds 1..4
`define CNT_W     6     // transfer counter, covers ROW_NUM*COL_WORDS

`endif
